// File: rvfi_check_config.svh
`ifndef RVFI_CHECK_CONFIG_SVH
`define RVFI_CHECK_CONFIG_SVH

// Data and address width of the checked core.
`define RVFI_XLEN 32

`define RVFI_ILEN 32

`define RVFI_MASK_W (`RVFI_XLEN / 8)

// A set value makes a misaligned load or store a specified trap.
`define RVFI_TRAP_MISALIGN 1

// Pipeline registers between decode and compare.
`define RVFI_PIPE_DEPTH 1

`endif

// File: rvfi_check_pkg.sv
`include "rvfi_check_config.svh"

package rvfi_check_pkg;

	typedef struct packed {
		logic [`RVFI_ILEN-1:0]   insn;
		logic                    trap;
		logic [4:0]              rs1_addr;
		logic [4:0]              rs2_addr;
		logic [`RVFI_XLEN-1:0]   rs1_rdata;
		logic [`RVFI_XLEN-1:0]   rs2_rdata;
		logic [4:0]              rd_addr;
		logic [`RVFI_XLEN-1:0]   rd_wdata;
		logic [`RVFI_XLEN-1:0]   pc_rdata;
		logic [`RVFI_XLEN-1:0]   pc_wdata;
		logic [`RVFI_XLEN-1:0]   mem_addr;
		logic [`RVFI_MASK_W-1:0] mem_rmask;
		logic [`RVFI_MASK_W-1:0] mem_wmask;
		logic [`RVFI_XLEN-1:0]   mem_rdata;
		logic [`RVFI_XLEN-1:0]   mem_wdata;
	} rvfi_rec_t;

	typedef enum logic [3:0] {
		ALU_REG, ALU_IMM, LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, ILLEGAL
	} insn_class_e;

	typedef struct packed {
		insn_class_e           cls;
		logic [2:0]            funct3;
		logic                  funct7_5;
		logic [4:0]            rs1_addr;
		logic [4:0]            rs2_addr;
		logic [4:0]            rd_addr;
		logic [`RVFI_XLEN-1:0] imm; // Already sign extended.
		logic                  use_rs1;
		logic                  use_rs2;
	} dec_t;

	typedef struct packed {
		logic                    trap;
		logic [4:0]              rs1_addr;
		logic [4:0]              rs2_addr;
		logic [4:0]              rd_addr;
		logic [`RVFI_XLEN-1:0]   rd_wdata;
		logic [`RVFI_XLEN-1:0]   pc_wdata;
		logic [`RVFI_XLEN-1:0]   mem_addr;
		logic [`RVFI_MASK_W-1:0] mem_rmask;
		logic [`RVFI_MASK_W-1:0] mem_wmask;
		logic [`RVFI_XLEN-1:0]   mem_wdata;
	} spec_t;

	typedef struct packed {
		rvfi_rec_t rec;
		dec_t      dec;
	} dec_item_t;

	typedef struct packed {
		rvfi_rec_t rec;
		spec_t     spec;
	} spec_item_t;

	// One flag per record field that disagrees with the specification.
	typedef struct packed {
		logic trap;
		logic rs1_addr;
		logic rs2_addr;
		logic rd_addr;
		logic rd_wdata;
		logic pc_wdata;
		logic mem_addr;
		logic mem_wmask;
		logic mem_wdata;
		logic mem_rmask;
	} mismatch_t;

	typedef struct packed {
		logic [`RVFI_XLEN-1:0] pc_rdata;
		logic [`RVFI_ILEN-1:0] insn;
		mismatch_t             mismatch;
		logic                  ok;
	} verdict_t;

endpackage

// File: insn_decode.sv
`timescale 1ns/10ps
`include "rvfi_check_config.svh"

module insn_decode import rvfi_check_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       rec_req,
	input  rvfi_rec_t  rec,
	output logic       rec_ack,
	output logic       out_valid,
	output dec_item_t  out,
	input  logic       stall
);

	rvfi_rec_t cap;
	logic      cap_valid;
	logic      capture;
	logic      advance;

	function automatic dec_t decode_insn(input logic [`RVFI_ILEN-1:0] insn);
		dec_t       d;
		logic [6:0] f7;
		d = '0;
		d.cls = ILLEGAL;
		f7 = insn[31:25];
		d.funct3 = insn[14:12];
		d.funct7_5 = insn[30];
		case (insn[6:0])
			7'b0110011: begin
				if (f7 == 7'b0 || (f7 == 7'b0100000 && insn[14:12] == 3'b000 ||
						f7 == 7'b0100000 && insn[14:12] == 3'b101))
					d.cls = ALU_REG;
			end
			7'b0010011: begin
				d.imm = {{20{insn[31]}}, insn[31:20]};
				if (insn[13:12] != 2'b01) // Only the shifts constrain funct7.
					d.cls = ALU_IMM;
				else if (f7 == 7'b0 || (insn[14] && f7 == 7'b0100000))
					d.cls = ALU_IMM;
			end
			7'b0110111: begin
				d.cls = LUI;
				d.imm = {insn[31:12], 12'b0};
			end
			7'b0010111: begin
				d.cls = AUIPC;
				d.imm = {insn[31:12], 12'b0};
			end
			7'b1101111: begin
				d.cls = JAL;
				d.imm = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
			end
			7'b1100111: begin
				d.imm = {{20{insn[31]}}, insn[31:20]};
				if (insn[14:12] == 3'b000)
					d.cls = JALR;
			end
			7'b1100011: begin
				d.imm = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
				if (insn[14:13] != 2'b01)
					d.cls = BRANCH;
			end
			7'b0000011: begin
				d.imm = {{20{insn[31]}}, insn[31:20]};
				if (insn[13:12] != 2'b11 && insn[14:13] != 2'b11)
					d.cls = LOAD;
			end
			7'b0100011: begin
				d.imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
				if (!insn[14] && insn[13:12] != 2'b11)
					d.cls = STORE;
			end
			default: ;
		endcase
		d.use_rs1 = d.cls inside {ALU_REG, ALU_IMM, JALR, BRANCH, LOAD, STORE};
		d.use_rs2 = d.cls inside {ALU_REG, BRANCH, STORE};
		d.rs1_addr = d.use_rs1 ? insn[19:15] : 5'd0;
		d.rs2_addr = d.use_rs2 ? insn[24:20] : 5'd0;
		d.rd_addr = (d.cls inside {BRANCH, STORE, ILLEGAL}) ? 5'd0 : insn[11:7];
		return d;
	endfunction

	assign capture = rec_req && !rec_ack && !cap_valid;
	assign advance = !out_valid || !stall; // The output slot is empty or draining.

	always_ff @(posedge clock) begin
		if (reset) begin
			rec_ack <= 1'b0;
			cap_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			if (capture)
				rec_ack <= 1'b1;
			else if (!rec_req)
				rec_ack <= 1'b0;
			if (capture)
				cap_valid <= 1'b1;
			else if (advance)
				cap_valid <= 1'b0;
			if (advance)
				out_valid <= cap_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (capture)
			cap <= rec;
		if (advance && cap_valid) begin
			out.rec <= cap;
			out.dec <= decode_insn(cap.insn);
		end
	end

endmodule

// File: check_stage.sv
`timescale 1ns/10ps

module check_stage #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     in_valid,
	input  payload_t in,
	input  logic     stall,
	output logic     out_valid,
	output payload_t out,
	output logic     ready
);

	assign ready = !out_valid || !stall;

	always_ff @(posedge clock) begin
		if (reset)
			out_valid <= 1'b0;
		else if (ready)
			out_valid <= in_valid;
	end

	// A stalled stage keeps its item.
	always_ff @(posedge clock) begin
		if (ready && in_valid)
			out <= in;
	end

endmodule

// File: insn_spec_exec.sv
`timescale 1ns/10ps
`include "rvfi_check_config.svh"

module insn_spec_exec import rvfi_check_pkg::*; (
	input  dec_item_t  in,
	input  logic       in_valid,
	output spec_item_t out,
	output logic       out_valid
);

	dec_t                    d;
	logic [`RVFI_XLEN-1:0]   rs1, rs2, pc, op_b, alu, sra_res, jalr_sum;
	logic [`RVFI_XLEN-1:0]   next_pc, addr, ld_shift, ld_data, result;
	logic [4:0]              shamt;
	logic [4:0]              lane_bits;
	logic                    cmp, taken, is_mem, mem_mis, pc_mis, trap;
	logic [`RVFI_MASK_W-1:0] size_mask, lane_mask;

	assign d = in.dec;
	assign rs1 = in.rec.rs1_rdata;
	assign rs2 = in.rec.rs2_rdata;
	assign pc = in.rec.pc_rdata;
	assign op_b = (d.cls == ALU_REG) ? rs2 : d.imm;
	assign shamt = op_b[4:0];
	assign sra_res = $signed(rs1) >>> shamt;
	assign jalr_sum = rs1 + d.imm;
	assign addr = rs1 + d.imm;
	assign lane_bits = {addr[1:0], 3'b000};
	assign ld_shift = in.rec.mem_rdata >> lane_bits; // Loaded bytes moved down to lane 0.
	assign is_mem = d.cls inside {LOAD, STORE};

	always_comb begin
		case (d.funct3)
			3'b000:  alu = (d.cls == ALU_REG && d.funct7_5) ? rs1 - op_b : rs1 + op_b;
			3'b001:  alu = rs1 << shamt;
			3'b010:  alu = {{(`RVFI_XLEN-1){1'b0}}, $signed(rs1) < $signed(op_b)};
			3'b011:  alu = {{(`RVFI_XLEN-1){1'b0}}, rs1 < op_b};
			3'b100:  alu = rs1 ^ op_b;
			3'b101:  alu = d.funct7_5 ? sra_res : rs1 >> shamt;
			3'b110:  alu = rs1 | op_b;
			default: alu = rs1 & op_b;
		endcase
		case (d.funct3[2:1])
			2'b00:   cmp = rs1 == rs2;
			2'b10:   cmp = $signed(rs1) < $signed(rs2);
			default: cmp = rs1 < rs2;
		endcase
		taken = cmp ^ d.funct3[0]; // Odd funct3 values invert the test.
		case (d.cls)
			JAL:     next_pc = pc + d.imm;
			JALR:    next_pc = {jalr_sum[`RVFI_XLEN-1:1], 1'b0};
			BRANCH:  next_pc = taken ? pc + d.imm : pc + 32'd4;
			default: next_pc = pc + 32'd4;
		endcase
		pc_mis = (d.cls inside {JAL, JALR} || (d.cls == BRANCH && taken)) &&
			next_pc[1:0] != 2'b00;
	end

	always_comb begin
		case (d.funct3[1:0])
			2'b00: begin
				size_mask = 4'b0001;
				mem_mis = 1'b0;
			end
			2'b01: begin
				size_mask = 4'b0011;
				mem_mis = addr[0];
			end
			default: begin
				size_mask = 4'b1111;
				mem_mis = addr[1:0] != 2'b00;
			end
		endcase
		lane_mask = size_mask << addr[1:0];
		case (d.funct3)
			3'b000:  ld_data = {{24{ld_shift[7]}}, ld_shift[7:0]};
			3'b001:  ld_data = {{16{ld_shift[15]}}, ld_shift[15:0]};
			3'b100:  ld_data = {24'b0, ld_shift[7:0]};
			3'b101:  ld_data = {16'b0, ld_shift[15:0]};
			default: ld_data = ld_shift;
		endcase
		case (d.cls)
			ALU_REG, ALU_IMM: result = alu;
			LUI:              result = d.imm;
			AUIPC:            result = pc + d.imm;
			JAL, JALR:        result = pc + 32'd4;
			LOAD:             result = ld_data;
			default:          result = '0;
		endcase
		trap = d.cls == ILLEGAL || pc_mis ||
			(is_mem && mem_mis && `RVFI_TRAP_MISALIGN != 0);
	end

	always_comb begin
		out.rec = in.rec;
		out.spec = '0;
		out.spec.trap = trap;
		out.spec.rs1_addr = d.rs1_addr;
		out.spec.rs2_addr = d.rs2_addr;
		out.spec.pc_wdata = next_pc;
		if (!trap) begin
			out.spec.rd_addr = d.rd_addr;
			out.spec.rd_wdata = (d.rd_addr != 5'd0) ? result : '0; // x0 never reports data.
			out.spec.mem_addr = is_mem ? {addr[`RVFI_XLEN-1:2], 2'b00} : '0;
			out.spec.mem_rmask = (d.cls == LOAD) ? lane_mask : '0;
			out.spec.mem_wmask = (d.cls == STORE) ? lane_mask : '0;
			out.spec.mem_wdata = (d.cls == STORE) ? rs2 << lane_bits : '0;
		end
	end

	assign out_valid = in_valid;

endmodule

// File: retire_compare.sv
`timescale 1ns/10ps
`include "rvfi_check_config.svh"

module retire_compare import rvfi_check_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       in_valid,
	input  spec_item_t in,
	output logic       stall,
	output logic       result_req,
	output verdict_t   result,
	input  logic       result_ack
);

	rvfi_rec_t rc;
	spec_t     sp;
	mismatch_t m;
	logic      v_full;
	logic      done;
	logic      load;

	assign rc = in.rec;
	assign sp = in.spec;

	always_comb begin
		m = '0;
		if (sp.trap) begin
			m.trap = !rc.trap;
			m.rd_addr = rc.rd_addr != 5'd0;
			m.rd_wdata = rc.rd_wdata != '0;
			m.mem_wmask = rc.mem_wmask != '0;
		end else begin
			m.trap = rc.trap;
			m.rs1_addr = sp.rs1_addr != rc.rs1_addr;
			m.rs2_addr = sp.rs2_addr != rc.rs2_addr;
			m.rd_addr = sp.rd_addr != rc.rd_addr;
			m.rd_wdata = sp.rd_wdata != rc.rd_wdata;
			m.pc_wdata = sp.pc_wdata != rc.pc_wdata;
			m.mem_addr = (sp.mem_rmask != '0 || sp.mem_wmask != '0) &&
				sp.mem_addr != rc.mem_addr;
			for (int i = 0; i < `RVFI_MASK_W; i++) begin
				if (sp.mem_wmask[i]) begin
					m.mem_wmask = m.mem_wmask | !rc.mem_wmask[i];
					m.mem_wdata = m.mem_wdata |
						(sp.mem_wdata[i*8 +: 8] != rc.mem_wdata[i*8 +: 8]);
				end else if (rc.mem_wmask[i]) begin
					// An extra written byte is only legal as a read-back.
					m.mem_wmask = m.mem_wmask | !rc.mem_rmask[i];
					m.mem_wdata = m.mem_wdata |
						(rc.mem_rdata[i*8 +: 8] != rc.mem_wdata[i*8 +: 8]);
				end
				if (sp.mem_rmask[i])
					m.mem_rmask = m.mem_rmask | !rc.mem_rmask[i];
			end
		end
	end

	assign done = result_req && result_ack;
	assign stall = v_full && !done;
	assign load = in_valid && !stall;

	always_ff @(posedge clock) begin
		if (reset) begin
			v_full <= 1'b0;
			result_req <= 1'b0;
		end else begin
			if (load)
				v_full <= 1'b1;
			else if (done)
				v_full <= 1'b0;
			if (done)
				result_req <= 1'b0;
			else if ((load || v_full) && !result_ack) // Wait for the previous ack to fall.
				result_req <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			result.pc_rdata <= rc.pc_rdata;
			result.insn <= rc.insn;
			result.mismatch <= m;
			result.ok <= m == '0;
		end
	end

endmodule

// File: rvfi_insn_checker.sv
`timescale 1ns/10ps
`include "rvfi_check_config.svh"

module rvfi_insn_checker import rvfi_check_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      rec_req,
	input  rvfi_rec_t rec,
	output logic      rec_ack,
	output logic      result_req,
	output verdict_t  result,
	input  logic      result_ack
);

	logic       dec_valid, exe_valid, spec_valid, st_valid;
	logic       dec_ready, spec_ready, cmp_stall;
	dec_item_t  dec_item, exe_item;
	spec_item_t spec_item, st_item;

	insn_decode decode_i (
		.clock, .reset, .rec_req, .rec, .rec_ack,
		.out_valid(dec_valid), .out(dec_item), .stall(!dec_ready)
	);

	generate
		if (`RVFI_PIPE_DEPTH > 1) begin : g_dec_stage
			check_stage #(.payload_t(dec_item_t)) dec_stage_i (
				.clock, .reset, .in_valid(dec_valid), .in(dec_item), .stall(!spec_ready),
				.out_valid(exe_valid), .out(exe_item), .ready(dec_ready)
			);
		end else begin : g_dec_direct
			assign exe_valid = dec_valid;
			assign exe_item = dec_item;
			assign dec_ready = spec_ready;
		end
	endgenerate

	insn_spec_exec exec_i (
		.in(exe_item), .in_valid(exe_valid), .out(spec_item), .out_valid(spec_valid)
	);

	check_stage #(.payload_t(spec_item_t)) spec_stage_i (
		.clock, .reset, .in_valid(spec_valid), .in(spec_item), .stall(cmp_stall),
		.out_valid(st_valid), .out(st_item), .ready(spec_ready)
	);

	retire_compare compare_i (
		.clock, .reset, .in_valid(st_valid), .in(st_item), .stall(cmp_stall),
		.result_req, .result, .result_ack
	);

endmodule

// File: rvfi_insn_checker_checker.sv
`timescale 1ns/10ps
`include "rvfi_check_config.svh"

module rvfi_insn_checker_checker import rvfi_check_pkg::*; (
	input logic      clock,
	input logic      reset,
	input logic      rec_req,
	input rvfi_rec_t rec,
	input logic      rec_ack,
	input logic      result_req,
	input verdict_t  result,
	input logic      result_ack
);

	// The source holds its record until the request falls.
	rec_stable: assert property (@(posedge clock) disable iff (reset)
		rec_req && $past(rec_req) |-> $stable(rec))
		else $error("Record changed while rec_req was high.");

	ack_needs_req: assert property (@(posedge clock) disable iff (reset)
		$rose(rec_ack) |-> $past(rec_req))
		else $error("rec_ack rose without rec_req.");

	result_stable: assert property (@(posedge clock) disable iff (reset)
		result_req && $past(result_req) |-> $stable(result))
		else $error("Verdict changed while result_req was high.");

	req_after_ack_low: assert property (@(posedge clock) disable iff (reset)
		$rose(result_req) |-> !$past(result_ack))
		else $error("result_req rose while result_ack was high.");

endmodule

bind rvfi_insn_checker rvfi_insn_checker_checker checker_i (.*);

// File: rvfi_insn_checker_tb.sv
`timescale 1ns/10ps
`include "rvfi_check_config.svh"

module rvfi_insn_checker_tb import rvfi_check_pkg::*; ();

	localparam int NUM_RECORDS = 44;
	localparam int CLK_PERIOD = 100;

	logic        clock = 1'b0;
	logic        reset = 1'b1;
	logic        rec_req = 1'b0;
	logic        result_ack = 1'b0;
	logic        rec_ack;
	logic        result_req;
	rvfi_rec_t   rec = '0;
	verdict_t    result;
	logic [31:0] lfsr = 32'hb956f0a4;
	logic [31:0] pc_cnt = 32'h0000_1000;
	verdict_t    exp_q[$];
	verdict_t    got_q[$];
	int          ack_delay = 0;
	int          ack_wait = 0;
	int          errors = 0;
	int          checks = 0;

	always #(CLK_PERIOD / 2) clock = !clock;

	rvfi_insn_checker dut_i (
		.clock, .reset, .rec_req, .rec, .rec_ack, .result_req, .result, .result_ack
	);

	// Receiver side, slowed down by ack_delay cycles per verdict.
	always @(posedge clock) begin
		if (reset) begin
			result_ack <= 1'b0;
			ack_wait <= 0;
		end else if (result_req && !result_ack) begin
			if (ack_wait >= ack_delay) begin
				result_ack <= 1'b1;
				got_q.push_back(result);
				ack_wait <= 0;
			end else begin
				ack_wait <= ack_wait + 1;
			end
		end else if (!result_req) begin
			result_ack <= 1'b0;
		end
	end

	function automatic logic [31:0] rnd(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic rvfi_rec_t base_rec(input logic [31:0] insn);
		rvfi_rec_t r;
		r = '0;
		pc_cnt = pc_cnt + 32'd4;
		r.insn = insn;
		r.pc_rdata = pc_cnt;
		r.pc_wdata = pc_cnt + 32'd4;
		return r;
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return sub ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (sub)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// Kind 0 is a register op, 1 an immediate op, 2 LUI and 3 AUIPC.
	function automatic rvfi_rec_t alu_rec(input int kind);
		rvfi_rec_t   r;
		logic [2:0]  f3;
		logic        sub;
		logic [4:0]  rd, rs1, rs2;
		logic [11:0] imm;
		logic [31:0] a, b;
		f3 = 3'(rnd(3));
		sub = (f3 == 3'd0 || f3 == 3'd5) ? 1'(rnd(1)) : 1'b0;
		rd = 5'(rnd(5)) | 5'd1;
		rs1 = 5'(rnd(5));
		rs2 = 5'(rnd(5));
		imm = 12'(rnd(12));
		a = rnd(32);
		b = rnd(32);
		case (kind)
			0: begin
				r = base_rec({1'b0, sub, 5'b0, rs2, rs1, f3, rd, 7'h33});
				r.rs1_addr = rs1;
				r.rs2_addr = rs2;
				r.rs2_rdata = b;
				r.rd_wdata = alu_ref(f3, sub, a, b);
			end
			1: begin
				if (f3 == 3'd1 || f3 == 3'd5)
					imm = {1'b0, sub, 5'b0, imm[4:0]};
				r = base_rec({imm, rs1, f3, rd, 7'h13});
				r.rs1_addr = rs1;
				r.rd_wdata = alu_ref(f3, f3 == 3'd5 && sub, a, {{20{imm[11]}}, imm});
			end
			2: begin
				r = base_rec({a[31:12], rd, 7'h37});
				r.rd_wdata = {a[31:12], 12'b0};
			end
			default: begin
				r = base_rec({a[31:12], rd, 7'h17});
				r.rd_wdata = r.pc_rdata + {a[31:12], 12'b0};
			end
		endcase
		r.rs1_rdata = a;
		r.rd_addr = rd;
		return r;
	endfunction

	// Loads read x8 plus a lane offset into x7, stores write x9 there.
	function automatic rvfi_rec_t mem_rec(input logic [2:0] f3, input logic store);
		rvfi_rec_t   r;
		logic [1:0]  lane;
		logic [3:0]  size;
		logic [31:0] a, b, sh;
		a = {28'(rnd(28)), 4'b0};
		b = rnd(32);
		lane = (f3[1:0] == 2'd0) ? 2'(rnd(2)) : (f3[1:0] == 2'd1) ? {1'(rnd(1)), 1'b0} : 2'd0;
		size = (f3[1:0] == 2'd0) ? 4'b0001 : (f3[1:0] == 2'd1) ? 4'b0011 : 4'b1111;
		if (store) begin
			r = base_rec({7'b0, 5'd9, 5'd8, f3, 3'b0, lane, 7'h23});
			r.rs2_addr = 5'd9;
			r.rs2_rdata = b;
			r.mem_wmask = size << lane;
			r.mem_wdata = (f3 == 3'd0) ? {4{b[7:0]}} : (f3 == 3'd1) ? {2{b[15:0]}} : b;
		end else begin
			r = base_rec({10'b0, lane, 5'd8, f3, 5'd7, 7'h03});
			r.rd_addr = 5'd7;
			r.mem_rmask = size << lane;
			r.mem_rdata = b;
			sh = b >> (8 * lane);
			case (f3)
				3'd0: r.rd_wdata = {{24{sh[7]}}, sh[7:0]};
				3'd1: r.rd_wdata = {{16{sh[15]}}, sh[15:0]};
				3'd4: r.rd_wdata = {24'b0, sh[7:0]};
				3'd5: r.rd_wdata = {16'b0, sh[15:0]};
				default: r.rd_wdata = sh;
			endcase
		end
		r.rs1_addr = 5'd8;
		r.rs1_rdata = a;
		r.mem_addr = a;
		return r;
	endfunction

	task automatic send(input rvfi_rec_t r, input mismatch_t m);
		verdict_t e;
		e.pc_rdata = r.pc_rdata;
		e.insn = r.insn;
		e.mismatch = m;
		e.ok = (m == '0);
		exp_q.push_back(e);
		@(posedge clock);
		rec <= r;
		rec_req <= 1'b1;
		do @(posedge clock); while (!rec_ack);
		rec_req <= 1'b0;
		do @(posedge clock); while (rec_ack);
	endtask

	task automatic drain();
		verdict_t g, e;
		while (got_q.size() < exp_q.size())
			@(posedge clock);
		while (exp_q.size() > 0) begin
			g = got_q.pop_front();
			e = exp_q.pop_front();
			checks++;
			assert (g.pc_rdata == e.pc_rdata) else begin
				errors++;
				$display("FAIL t=%0t result.pc_rdata got %h exp %h", $time, g.pc_rdata,
					e.pc_rdata);
			end
			assert (g.insn == e.insn) else begin
				errors++;
				$display("FAIL t=%0t result.insn got %h exp %h", $time, g.insn, e.insn);
			end
			assert (g.mismatch == e.mismatch) else begin
				errors++;
				$display("FAIL t=%0t result.mismatch got %b exp %b (pc %h)", $time,
					g.mismatch, e.mismatch, e.pc_rdata);
			end
			assert (g.ok == e.ok) else begin
				errors++;
				$display("FAIL t=%0t result.ok got %b exp %b (pc %h)", $time,
					g.ok, e.ok, e.pc_rdata);
			end
		end
	endtask

	task automatic test_alu();
		for (int i = 0; i < 12; i++)
			send(alu_rec(i % 4), '0);
		drain();
	endtask

	task automatic test_rd_corrupt();
		rvfi_rec_t r;
		r = alu_rec(0);
		r.rd_wdata = r.rd_wdata ^ 32'h0000_0100;
		send(r, mismatch_t'{rd_wdata: 1'b1, default: 1'b0});
		r = alu_rec(1);
		r.rd_addr = r.rd_addr ^ 5'd2;
		send(r, mismatch_t'{rd_addr: 1'b1, default: 1'b0});
		drain();
	endtask

	task automatic test_control();
		rvfi_rec_t   r;
		logic [31:0] a;
		a = rnd(32);
		r = base_rec({1'b0, 6'b0, 5'd2, 5'd1, 3'd0, 4'b1000, 1'b0, 7'h63}); // BEQ +16.
		r.rs1_addr = 5'd1;
		r.rs2_addr = 5'd2;
		r.rs1_rdata = a;
		r.rs2_rdata = a;
		r.pc_wdata = r.pc_rdata + 32'd16;
		send(r, '0);
		r.insn[14:12] = 3'd1; // Same operands as BNE fall through.
		r.pc_wdata = r.pc_rdata + 32'd4;
		send(r, '0);
		r = base_rec({1'b0, 10'h080, 1'b0, 8'h00, 5'd1, 7'h6f}); // JAL +0x100.
		r.rd_addr = 5'd1;
		r.rd_wdata = r.pc_rdata + 32'd4;
		r.pc_wdata = r.pc_rdata + 32'h100;
		send(r, '0);
		r.pc_wdata = r.pc_wdata + 32'd4;
		send(r, mismatch_t'{pc_wdata: 1'b1, default: 1'b0});
		a = {30'(rnd(30)), 2'b10};
		r = base_rec({12'd7, 5'd6, 3'd0, 5'd5, 7'h67}); // JALR with an odd sum.
		r.rs1_addr = 5'd6;
		r.rs1_rdata = a;
		r.rd_addr = 5'd5;
		r.rd_wdata = r.pc_rdata + 32'd4;
		r.pc_wdata = (a + 32'd7) & ~32'd1;
		send(r, '0);
		r = base_rec({1'b0, 10'h003, 1'b0, 8'h00, 5'd1, 7'h6f}); // JAL +6.
		r.trap = 1'b1;
		send(r, '0);
		r.trap = 1'b0;
		r.rd_addr = 5'd1;
		r.rd_wdata = r.pc_rdata + 32'd4;
		r.pc_wdata = r.pc_rdata + 32'd6;
		send(r, mismatch_t'{trap: 1'b1, rd_addr: 1'b1, rd_wdata: 1'b1, default: 1'b0});
		r = alu_rec(0);
		r.trap = 1'b1;
		send(r, mismatch_t'{trap: 1'b1, default: 1'b0});
		drain();
	endtask

	task automatic test_memory();
		rvfi_rec_t r;
		send(mem_rec(3'd0, 1'b0), '0);
		send(mem_rec(3'd1, 1'b0), '0);
		send(mem_rec(3'd2, 1'b0), '0);
		send(mem_rec(3'd4, 1'b0), '0);
		send(mem_rec(3'd5, 1'b0), '0);
		for (int f = 0; f < 3; f++)
			send(mem_rec(3'(f), 1'b1), '0);
		r = mem_rec(3'd2, 1'b1);
		r.mem_wmask = 4'b1110;
		send(r, mismatch_t'{mem_wmask: 1'b1, default: 1'b0});
		r = mem_rec(3'd2, 1'b1);
		r.mem_wdata[7:0] = ~r.mem_wdata[7:0];
		send(r, mismatch_t'{mem_wdata: 1'b1, default: 1'b0});
		r = mem_rec(3'd2, 1'b0);
		r.mem_addr = r.mem_addr ^ 32'h0000_0010;
		send(r, mismatch_t'{mem_addr: 1'b1, default: 1'b0});
		r = mem_rec(3'd1, 1'b0);
		r.mem_rmask = 4'b0000;
		send(r, mismatch_t'{mem_rmask: 1'b1, default: 1'b0});
		drain();
	endtask

	task automatic test_traps();
		rvfi_rec_t r;
		r = base_rec(32'h0000_0000);
		r.trap = 1'b1;
		send(r, '0);
		r = base_rec({12'd2, 5'd8, 3'd2, 5'd7, 7'h03}); // LW at word plus two.
		r.rs1_addr = 5'd8;
		r.rs1_rdata = {30'(rnd(30)), 2'b00};
		r.trap = 1'b1;
		send(r, '0);
		r.trap = 1'b0;
		send(r, mismatch_t'{trap: 1'b1, default: 1'b0});
		r.trap = 1'b1;
		r.rd_addr = 5'd7;
		send(r, mismatch_t'{rd_addr: 1'b1, default: 1'b0});
		drain();
	endtask

	task automatic test_backpressure();
		ack_delay = 20;
		for (int i = 0; i < 6; i++)
			send(alu_rec(i % 4), '0);
		drain();
		ack_delay = 0;
	endtask

	initial begin
		#((NUM_RECORDS * 40 + 16) * CLK_PERIOD);
		$display("Watchdog expired before all verdicts arrived.");
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		test_alu();
		test_rd_corrupt();
		test_control();
		test_memory();
		test_traps();
		test_backpressure();
		repeat (20) @(posedge clock);
		assert (got_q.size() == 0) else begin
			errors++;
			$display("More verdicts arrived than records were sent.");
		end
		$display("Errors: %0d in %0d verdict checks", errors, checks);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: rvfi_insn_checker.f
+incdir+.
rvfi_check_pkg.sv
insn_decode.sv
check_stage.sv
insn_spec_exec.sv
retire_compare.sv
rvfi_insn_checker.sv
rvfi_insn_checker_checker.sv
rvfi_insn_checker_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= rvfi_insn_checker_tb
FILELIST  ?= rvfi_insn_checker.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
